// File: logic/trig_pkg.sv
////////////////////////////////////////////////////////////
// shared sizes and types for the trigger path
// fifo_depth must be a power of two (pointer wrap bit)
// credit_w must hold fifo_depth itself, not just depth-1
////////////////////////////////////////////////////////////
`default_nettype none

package trig_pkg;

  // channel FPGAs fed by the trigger manager
  localparam int num_chan = 5;

  // fill type sent with each trigger
  // (muon fill, laser, pedestal, spare)
  localparam int fill_w = 2;

  // programmable trigger delay, in clk cycles
  localparam int delay_w = 4;

  // one word of trigger info for the command manager
  localparam int info_w = 64;

  // info FIFO entries, also the manager's starting credits
  localparam int fifo_depth = 8;
  localparam int ptr_w = $clog2(fifo_depth);
  localparam int credit_w = $clog2(fifo_depth + 1);

  // manager FSM states
  typedef enum logic [2:0] {
    idle,
    delay,
    fill,
    store_num,
    store_time
  } trig_state_t;

  // trigger number or timestamp word
  typedef logic [info_w-1:0] info_word_t;

endpackage

`default_nettype wire

// File: logic/trig_info_if.sv
////////////////////////////////////////////////////////////
// manager to info FIFO link, credit flow control
// one credit per free entry, FIFO has no ready signal
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

interface trig_info_if;
  import trig_pkg::*;

  // one-cycle write strobe, only sent with a credit in hand
  logic       wr_valid;
  info_word_t wr_data;
  // one pulse per popped word
  logic       credit_ret;
  // FIFO out of reset and ready to take writes
  logic       init_done;

  modport producer (
    output wr_valid,
    output wr_data,
    input  credit_ret,
    input  init_done
  );

  modport consumer (
    input  wr_valid,
    input  wr_data,
    output credit_ret,
    output init_done
  );

endinterface

`default_nettype wire

// File: logic/trigger_manager.sv
////////////////////////////////////////////////////////////
// trigger FSM: delay, fill, then store number and timestamp
// triggers outside idle are dropped, not queued
// store states stall while no credit is left
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module trigger_manager (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               reset_trig_num,
  input  logic                               reset_trig_timestamp,
  input  logic                               trigger,
  input  logic [trig_pkg::num_chan-1:0]      chan_en,
  input  logic [trig_pkg::fill_w-1:0]        fill_type,
  input  logic [trig_pkg::delay_w-1:0]       trig_delay,
  input  logic                               all_done,
  output logic [2*trig_pkg::num_chan-1:0]    acq_enable,
  output logic [trig_pkg::num_chan-1:0]      acq_trig,
  output logic                               in_fill,
  trig_info_if.producer                      info
);
  import trig_pkg::*;

  trig_state_t         state;
  trig_state_t         state_next;
  logic [delay_w-1:0]  delay_cnt;
  logic [info_w-1:0]   trig_num;
  logic [info_w-1:0]   ts_cnt;
  info_word_t          trig_time;
  logic [credit_w-1:0] credits;
  logic                accept;
  logic                can_write;
  logic                write_now;
  logic                wr_valid_q;
  info_word_t          wr_data_q;

  // trigger only counts when sampled in idle
  assign accept = (state == idle) && trigger;

  // a free FIFO slot is known to exist
  assign can_write = info.init_done && (credits != '0);
  assign write_now = can_write && ((state == store_num) || (state == store_time));

  // channel outputs are held for the whole fill state
  assign in_fill    = (state == fill);
  assign acq_trig   = in_fill ? chan_en : '0;
  assign acq_enable = in_fill ? {num_chan{fill_type}} : '0;

  assign info.wr_valid = wr_valid_q;
  assign info.wr_data  = wr_data_q;

  always_comb begin
    state_next = state;
    case (state)
      idle: begin
        // always pass through delay, even for zero
        if (trigger) begin
          state_next = delay;
        end
      end
      delay: begin
        if (delay_cnt == '0) begin
          state_next = fill;
        end
      end
      fill: begin
        if (all_done) begin
          state_next = store_num;
        end
      end
      store_num: begin
        if (can_write) begin
          state_next = store_time;
        end
      end
      store_time: begin
        if (can_write) begin
          state_next = idle;
        end
      end
      default: begin
        state_next = idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= idle;
    end else begin
      state <= state_next;
    end
  end

  // loaded on accept, counts down to zero in delay
  always_ff @(posedge clk) begin
    if (reset) begin
      delay_cnt <= '0;
    end else if (accept) begin
      delay_cnt <= trig_delay;
    end else if ((state == delay) && (delay_cnt != '0)) begin
      delay_cnt <= delay_cnt - 1'b1;
    end
  end

  // first accepted trigger after a clear reports 1
  always_ff @(posedge clk) begin
    if (reset || reset_trig_num) begin
      trig_num <= '0;
    end else if (accept) begin
      trig_num <= trig_num + 1'b1;
    end
  end

  // free-running cycle count
  always_ff @(posedge clk) begin
    if (reset || reset_trig_timestamp) begin
      ts_cnt <= '0;
    end else begin
      ts_cnt <= ts_cnt + 1'b1;
    end
  end

  // value of the count in the trigger-sampling cycle
  always_ff @(posedge clk) begin
    if (accept) begin
      trig_time <= ts_cnt;
    end
  end

  // spend one per write, regain one per FIFO pop
  always_ff @(posedge clk) begin
    if (reset) begin
      credits <= credit_w'(fifo_depth);
    end else begin
      credits <= credits - credit_w'(write_now) + credit_w'(info.credit_ret);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_valid_q <= 1'b0;
    end else begin
      wr_valid_q <= write_now;
    end
  end

  // number word first, then timestamp word
  always_ff @(posedge clk) begin
    if (write_now) begin
      wr_data_q <= (state == store_num) ? trig_num : trig_time;
    end
  end

endmodule

`default_nettype wire

// File: logic/acq_done_collector.sv
////////////////////////////////////////////////////////////
// sticky per-channel done bits for the current fill
// done may be a pulse or a level, collected only in fill
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module acq_done_collector (
  input  logic                          clk,
  input  logic                          reset,
  input  logic                          in_fill,
  input  logic [trig_pkg::num_chan-1:0] chan_en,
  input  logic [trig_pkg::num_chan-1:0] acq_done,
  output logic                          all_done
);
  import trig_pkg::*;

  logic                in_fill_q;
  logic                fill_start;
  logic [num_chan-1:0] done_seen;
  logic [num_chan-1:0] done_eff;

  // first cycle of a fill
  assign fill_start = in_fill && !in_fill_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      in_fill_q <= 1'b0;
    end else begin
      in_fill_q <= in_fill;
    end
  end

  // cleared on fill entry, so stale bits from
  // the previous trigger never count
  always_ff @(posedge clk) begin
    if (reset) begin
      done_seen <= '0;
    end else if (fill_start) begin
      done_seen <= acq_done;
    end else if (in_fill) begin
      done_seen <= done_seen | acq_done;
    end
  end

  // old bits are still in the register on the first fill cycle
  assign done_eff = fill_start ? '0 : done_seen;

  // disabled channels never hold things up
  // chan_en of zero is done at once
  assign all_done = ((chan_en & ~done_eff) == '0);

endmodule

`default_nettype wire

// File: logic/trigger_info_fifo.sv
////////////////////////////////////////////////////////////
// info word FIFO, read side is valid/ready
// no full flag, producer credits keep it from overflowing
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module trigger_info_fifo (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        info_ready,
  output logic                        info_valid,
  output logic [trig_pkg::info_w-1:0] info_data,
  trig_info_if.consumer               info
);
  import trig_pkg::*;

  info_word_t       mem [fifo_depth];
  // extra top bit tells full from empty on equal index
  logic [ptr_w:0]   wr_ptr;
  logic [ptr_w:0]   rd_ptr;
  logic             pop;
  logic             credit_ret_q;
  logic             init_done_q;

  // a word written on one edge shows on the next cycle
  assign info_valid = (wr_ptr != rd_ptr);
  assign info_data  = mem[rd_ptr[ptr_w-1:0]];

  // standard handshake
  assign pop = info_valid && info_ready;

  assign info.credit_ret = credit_ret_q;
  assign info.init_done  = init_done_q;

  // storage, no reset
  always_ff @(posedge clk) begin
    if (info.wr_valid) begin
      mem[wr_ptr[ptr_w-1:0]] <= info.wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (info.wr_valid) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
    end else if (pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

  // one credit back per word taken
  always_ff @(posedge clk) begin
    if (reset) begin
      credit_ret_q <= 1'b0;
    end else begin
      credit_ret_q <= pop;
    end
  end

  // goes high the cycle after reset drops
  always_ff @(posedge clk) begin
    if (reset) begin
      init_done_q <= 1'b0;
    end else begin
      init_done_q <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: logic/trigger_subsystem.sv
////////////////////////////////////////////////////////////
// trigger path top: manager, done collector, info FIFO
// single clock domain, no timeout on missing channels
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module trigger_subsystem (
  input  logic                               clk,
  input  logic                               reset,
  input  logic                               reset_trig_num,
  input  logic                               reset_trig_timestamp,
  input  logic                               trigger,
  input  logic [trig_pkg::num_chan-1:0]      chan_en,
  input  logic [trig_pkg::fill_w-1:0]        fill_type,
  input  logic [trig_pkg::delay_w-1:0]       trig_delay,
  input  logic [trig_pkg::num_chan-1:0]      acq_done,
  input  logic                               info_ready,
  output logic [2*trig_pkg::num_chan-1:0]    acq_enable,
  output logic [trig_pkg::num_chan-1:0]      acq_trig,
  output logic                               info_valid,
  output logic [trig_pkg::info_w-1:0]        info_data
);

  logic in_fill;
  logic all_done;

  // manager to FIFO words and credits
  trig_info_if info_bus ();

  trigger_manager u_manager (
    .clk                  (clk),
    .reset                (reset),
    .reset_trig_num       (reset_trig_num),
    .reset_trig_timestamp (reset_trig_timestamp),
    .trigger              (trigger),
    .chan_en              (chan_en),
    .fill_type            (fill_type),
    .trig_delay           (trig_delay),
    .all_done             (all_done),
    .acq_enable           (acq_enable),
    .acq_trig             (acq_trig),
    .in_fill              (in_fill),
    .info                 (info_bus.producer)
  );

  acq_done_collector u_collector (
    .clk      (clk),
    .reset    (reset),
    .in_fill  (in_fill),
    .chan_en  (chan_en),
    .acq_done (acq_done),
    .all_done (all_done)
  );

  trigger_info_fifo u_info_fifo (
    .clk        (clk),
    .reset      (reset),
    .info_ready (info_ready),
    .info_valid (info_valid),
    .info_data  (info_data),
    .info       (info_bus.consumer)
  );

endmodule

`default_nettype wire

// File: testbench/tb_checker.sv
////////////////////////////////////////////////////////////
// watches the trigger subsystem ports and counts errors
// info words are predicted by tb_top and queued here
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_checker (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [trig_pkg::num_chan-1:0]      acq_trig,
  input  logic [trig_pkg::num_chan-1:0]      acq_done,
  input  logic [2*trig_pkg::num_chan-1:0]    acq_enable,
  input  logic                               info_valid,
  input  logic                               info_ready,
  input  logic [trig_pkg::info_w-1:0]        info_data,
  input  logic                               arm,
  input  logic [trig_pkg::delay_w-1:0]       exp_delay,
  input  logic [trig_pkg::num_chan-1:0]      exp_trig,
  input  logic [2*trig_pkg::num_chan-1:0]    exp_en,
  input  logic                               push,
  input  logic [trig_pkg::info_w-1:0]        push_num,
  input  logic [trig_pkg::info_w-1:0]        push_time,
  input  logic                               test_done,
  input  int                                 test_id,
  output int                                 pending,
  output int                                 pass_cnt,
  output int                                 fail_cnt
);
  import trig_pkg::*;

  logic [info_w-1:0]     exp_q [$];
  logic [info_w-1:0]     exp_word;
  logic [delay_w-1:0]    d_q;
  logic [num_chan-1:0]   t_q;
  logic [2*num_chan-1:0] e_q;
  logic [num_chan-1:0]   seen;
  logic [num_chan-1:0]   trig_q;
  logic                  covered;
  logic                  late;
  logic                  armed;
  int                    edges;
  int                    errors;

  initial begin
    pending  = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    errors   = 0;
    armed    = 1'b0;
    covered  = 1'b0;
    late     = 1'b0;
    seen     = '0;
    trig_q   = '0;
  end

  always @(posedge clk) begin
    if (push) begin
      exp_q.push_back(push_num);
      exp_q.push_back(push_time);
    end
    // one word per handshake in order
    if (!reset && info_valid && info_ready) begin
      if (exp_q.size() == 0) begin
        $display("unexpected info word 0x%h with nothing predicted", info_data);
        errors++;
      end else begin
        exp_word = exp_q.pop_front();
        if (info_data !== exp_word) begin
          $display("MISMATCH info_data got 0x%h expected 0x%h", info_data, exp_word);
          errors++;
        end
      end
    end
    pending = exp_q.size();
    // channels must stay quiet for 1 + delay cycles
    if (armed) begin
      edges++;
      if (edges < 2 + int'(d_q)) begin
        if (acq_trig !== '0) begin
          $display("MISMATCH acq_trig early got 0x%h expected 0x0", acq_trig);
          errors++;
        end
      end else begin
        if (acq_trig !== t_q) begin
          $display("MISMATCH acq_trig got 0x%h expected 0x%h", acq_trig, t_q);
          errors++;
        end
        if (acq_enable !== e_q) begin
          $display("MISMATCH acq_enable got 0x%h expected 0x%h", acq_enable, e_q);
          errors++;
        end
        armed = 1'b0;
      end
    end
    if (arm) begin
      armed = 1'b1;
      edges = 0;
      d_q   = exp_delay;
      t_q   = exp_trig;
      e_q   = exp_en;
    end
    // fill ends exactly one cycle after the last done
    if (acq_trig != '0) begin
      if (late) begin
        $display("acq_trig still high two cycles after the last enabled channel was done");
        errors++;
      end
      late    = covered;
      seen    = seen | acq_done;
      covered = ((acq_trig & ~seen) == '0);
    end else begin
      if ((trig_q != '0) && !late) begin
        $display("acq_trig fell before the cycle after the last enabled channel was done");
        errors++;
      end
      seen    = '0;
      covered = 1'b0;
      late    = 1'b0;
    end
    trig_q = acq_trig;
    if (test_done) begin
      if (errors == 0) begin
        pass_cnt++;
        $display("test %0d passed", test_id);
      end else begin
        fail_cnt++;
        $display("test %0d failed with %0d errors", test_id, errors);
      end
      errors = 0;
    end
  end

endmodule

`default_nettype wire

// File: testbench/tb_top.sv
////////////////////////////////////////////////////////////
// trigger subsystem testbench with one table row per test
// inputs change on falling edges, channels are modeled here
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_top;
  import trig_pkg::*;

  typedef struct packed {
    logic [delay_w-1:0]    delay;
    logic [num_chan-1:0]   en;
    logic [fill_w-1:0]     fill;
    logic [4*num_chan-1:0] lat;
    logic                  level;
    logic [3:0]            stall;
    logic                  clr_num;
    logic                  clr_ts;
    logic                  busy;
  } row_t;

  localparam int num_rows = 9;
  localparam int timeout_cycles = 400;

  logic                  clk = 1'b0;
  logic                  reset;
  logic                  reset_trig_num;
  logic                  reset_trig_timestamp;
  logic                  trigger;
  logic [num_chan-1:0]   chan_en;
  logic [fill_w-1:0]     fill_type;
  logic [delay_w-1:0]    trig_delay;
  wire  [num_chan-1:0]   acq_done;
  logic                  info_ready;
  logic [2*num_chan-1:0] acq_enable;
  logic [num_chan-1:0]   acq_trig;
  logic                  info_valid;
  logic [info_w-1:0]     info_data;
  logic                  arm;
  logic                  push;
  logic                  test_done;
  logic [info_w-1:0]     push_num;
  logic [info_w-1:0]     push_time;
  logic [delay_w-1:0]    exp_delay;
  logic [num_chan-1:0]   exp_trig;
  logic [2*num_chan-1:0] exp_en;
  logic [4*num_chan-1:0] cur_lat;
  logic                  cur_level;
  logic                  timed_out;
  int                    test_id;
  int                    pending;
  int                    pass_cnt;
  int                    fail_cnt;
  int                    cyc = 0;
  int                    clr_at;
  int                    trig_count;
  row_t                  rows [num_rows];

  trigger_subsystem dut (
    .clk (clk), .reset (reset), .reset_trig_num (reset_trig_num),
    .reset_trig_timestamp (reset_trig_timestamp), .trigger (trigger),
    .chan_en (chan_en), .fill_type (fill_type), .trig_delay (trig_delay),
    .acq_done (acq_done), .info_ready (info_ready), .acq_enable (acq_enable),
    .acq_trig (acq_trig), .info_valid (info_valid), .info_data (info_data)
  );

  tb_checker u_checker (
    .clk (clk), .reset (reset), .acq_trig (acq_trig), .acq_done (acq_done),
    .acq_enable (acq_enable), .info_valid (info_valid), .info_ready (info_ready),
    .info_data (info_data), .arm (arm), .exp_delay (exp_delay), .exp_trig (exp_trig),
    .exp_en (exp_en), .push (push), .push_num (push_num), .push_time (push_time),
    .test_done (test_done), .test_id (test_id), .pending (pending),
    .pass_cnt (pass_cnt), .fail_cnt (fail_cnt)
  );

  initial begin
    forever #20 clk = ~clk;
  end

  // edge count for expected timestamps
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  // channel FPGA model answers acq_trig after its latency
  genvar g;
  generate
    for (g = 0; g < num_chan; g++) begin : chan_model
      logic       busy = 1'b0;
      logic       fired = 1'b0;
      logic       done_q = 1'b0;
      logic [3:0] left;
      assign acq_done[g] = done_q;
      always @(negedge clk) begin
        if (reset || !acq_trig[g]) begin
          busy   = 1'b0;
          fired  = 1'b0;
          done_q = 1'b0;
        end else if (!busy) begin
          busy = 1'b1;
          left = cur_lat[g*4 +: 4];
        end else if (left != 4'd0) begin
          left = left - 1'b1;
        end else if (!fired) begin
          done_q = 1'b1;
          fired  = 1'b1;
        end else if (!cur_level) begin
          // pulse style drops done after one cycle
          done_q = 1'b0;
        end
      end
    end
  endgenerate

  task automatic wait_trig(input logic level, input string what);
    int n;
    n = 0;
    while (((acq_trig != '0) != level) && !timed_out) begin
      @(negedge clk);
      n++;
      if (n > timeout_cycles) begin
        timed_out = 1'b1;
        $display("timeout waiting for %s", what);
      end
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while ((pending != 0) && !timed_out) begin
      @(negedge clk);
      n++;
      if (n > timeout_cycles) begin
        timed_out = 1'b1;
        $display("timeout waiting for %0d info words", pending);
      end
    end
  endtask

  // counted triggers are expected to be accepted in idle
  task automatic send_trigger(input logic counted);
    trigger = 1'b1;
    if (counted) begin
      trig_count++;
      arm       = 1'b1;
      push      = 1'b1;
      push_num  = 64'(trig_count);
      push_time = 64'(cyc - clr_at - 1);
    end
    @(negedge clk);
    trigger = 1'b0;
    arm     = 1'b0;
    push    = 1'b0;
  endtask

  task automatic run_row(input row_t r);
    trig_delay = r.delay;
    chan_en    = r.en;
    fill_type  = r.fill;
    cur_lat    = r.lat;
    cur_level  = r.level;
    exp_delay  = r.delay;
    exp_trig   = r.en;
    exp_en     = {num_chan{r.fill}};
    @(negedge clk);
    if (r.clr_num || r.clr_ts) begin
      reset_trig_num       = r.clr_num;
      reset_trig_timestamp = r.clr_ts;
      if (r.clr_ts) begin
        clr_at = cyc;
      end
      if (r.clr_num) begin
        trig_count = 0;
      end
      @(negedge clk);
      reset_trig_num       = 1'b0;
      reset_trig_timestamp = 1'b0;
    end
    if (r.stall == 4'd0) begin
      info_ready = 1'b1;
      send_trigger(1'b1);
      if (r.busy) begin
        // once in delay, once in fill
        send_trigger(1'b0);
        wait_trig(1'b1, "acq_trig to rise");
        send_trigger(1'b0);
      end
    end else begin
      // four triggers fill the FIFO, the fifth stalls in store_num
      info_ready = 1'b0;
      for (int t = 0; t < int'(r.stall); t++) begin
        if (t < 5) begin
          send_trigger(1'b1);
          wait_trig(1'b1, "acq_trig to rise");
          wait_trig(1'b0, "acq_trig to fall");
          repeat (2) @(negedge clk);
        end else begin
          repeat ($urandom % 3) @(negedge clk);
          send_trigger(1'b0);
        end
      end
      info_ready = 1'b1;
    end
    wait_drain();
  endtask

  initial begin
    void'($urandom(4482));
    reset = 1'b1;
    reset_trig_num = 1'b0;
    reset_trig_timestamp = 1'b0;
    trigger = 1'b0;
    chan_en = '0;
    fill_type = '0;
    trig_delay = '0;
    info_ready = 1'b1;
    arm = 1'b0;
    push = 1'b0;
    test_done = 1'b0;
    test_id = 0;
    push_num = '0;
    push_time = '0;
    exp_delay = '0;
    exp_trig = '0;
    exp_en = '0;
    cur_lat = '0;
    cur_level = 1'b0;
    timed_out = 1'b0;
    trig_count = 0;
    // delay, en, fill, latencies (chan 4..0), level, stall, clr_num, clr_ts, busy
    rows[0] = '{4'd0, 5'h1f, 2'd1, 20'h43210, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0};
    rows[1] = '{4'd1, 5'h0a, 2'd2, 20'h07050, 1'b1, 4'd0, 1'b0, 1'b0, 1'b0};
    rows[2] = '{4'd15, 5'h11, 2'd3, 20'h20003, 1'b1, 4'd0, 1'b0, 1'b0, 1'b0};
    rows[3] = '{4'd2, 5'h00, 2'd3, 20'h00000, 1'b0, 4'd0, 1'b0, 1'b0, 1'b0};
    rows[4] = '{4'd3, 5'h1f, 2'd2, 20'h12345, 1'b0, 4'd0, 1'b1, 1'b0, 1'b0};
    rows[5] = '{4'd0, 5'h07, 2'd1, 20'h00312, 1'b1, 4'd0, 1'b0, 1'b1, 1'b0};
    rows[6] = '{4'd1, 5'h1c, 2'd3, 20'h34200, 1'b0, 4'd0, 1'b0, 1'b0, 1'b1};
    rows[7] = '{4'd0, 5'h03, 2'd1, 20'h00021, 1'b0, 4'd7, 1'b0, 1'b0, 1'b0};
    rows[8] = '{4'd2, 5'h15, 2'd2, 20'h10101, 1'b1, 4'd0, 1'b0, 1'b0, 1'b0};
    repeat (8) @(negedge clk);
    reset = 1'b0;
    // last clearing edge was the final reset edge
    clr_at = cyc - 1;
    for (int i = 0; i < num_rows; i++) begin
      if (!timed_out) begin
        run_row(rows[i]);
        test_id   = i;
        test_done = 1'b1;
        @(negedge clk);
        test_done = 1'b0;
      end
    end
    @(negedge clk);
    $display("%0d tests passed, %0d tests failed", pass_cnt, fail_cnt);
    if (timed_out || (fail_cnt != 0) || (pending != 0)) begin
      $display("SOME TESTS FAILED");
    end else begin
      $display("ALL TESTS PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
logic/trig_pkg.sv
logic/trig_info_if.sv
logic/trigger_manager.sv
logic/acq_done_collector.sv
logic/trigger_info_fifo.sv
logic/trigger_subsystem.sv
testbench/tb_checker.sv
testbench/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator, status follows the testbench verdict
cd "$(dirname "$0")" &&
verilator --binary --timing -f filelist.f --top-module tb_top -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" &&
echo "simulation result: pass" ||
{ echo "simulation result: fail"; exit 1; }
